// File: lsu.f
design/lsu_pkg.sv
design/lsu_req_if.sv
design/lsu_mem_if.sv
design/lsu_request_stage.sv
design/lsu_data_ram.sv
design/lsu_load_align.sv
design/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv

// File: tests/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  logic                clk;
  logic                rst;
  logic                mem_rd;
  logic                mem_wr;
  logic [OP_WIDTH-1:0] mem_op;
  logic [ADDR_W-1:0]   addr;
  logic [XLEN-1:0]     wdata;
  logic                done;
  logic                fault;
  logic [XLEN-1:0]     rdata;
  int                  errors;
  int                  skipped;
  int                  in_flight;
  logic [31:0]         rand_state;
  logic [ADDR_W-1:0]   last_addr;
  logic                timed_out;

  // 4 ns clock.
  initial clk = 1'b0;
  always #2 clk = ~clk;

  lsu_top i_dut (
    .clk    (clk),
    .rst    (rst),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr),
    .mem_op (mem_op),
    .addr   (addr),
    .wdata  (wdata),
    .done   (done),
    .fault  (fault),
    .rdata  (rdata)
  );

  lsu_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_op    (mem_op),
    .addr      (addr),
    .wdata     (wdata),
    .done      (done),
    .fault     (fault),
    .rdata     (rdata),
    .errors    (errors),
    .skipped   (skipped),
    .in_flight (in_flight)
  );

  // Linear congruential generator.
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Drive one cycle of inputs on the falling edge.
  task automatic issue(input logic rd, input logic wr, input logic [OP_WIDTH-1:0] op,
                       input logic [ADDR_W-1:0] a, input logic [XLEN-1:0] d);
    @(negedge clk);
    mem_rd = rd;
    mem_wr = wr;
    mem_op = op;
    addr   = a;
    wdata  = d;
  endtask

  // One random cycle, idle, load, store or both strobes.
  task automatic random_cycle();
    logic [31:0]       r;
    logic [31:0]       s;
    logic [ADDR_W-1:0] a;
    logic [3:0]        kind;
    r    = next_rand();
    s    = next_rand();
    kind = r[3:0];
    a    = s[ADDR_W-1:0];
    // Mostly aligned, so that most accesses reach the RAM.
    if (r[9:7] != 3'b000) begin
      case (r[5:4])
        2'b01:   a[0]   = 1'b0;
        2'b10:   a[1:0] = 2'b00;
        2'b11:   a[2:0] = 3'b000;
        default: a      = a;
      endcase
    end
    // Now and then hit the word of the previous access.
    if (r[12:10] == 3'b000) begin
      a[ADDR_W-1:3] = last_addr[ADDR_W-1:3];
    end
    if (kind < 4'd3) begin
      issue(1'b0, 1'b0, r[6:4], a, {next_rand(), next_rand()});
    end else begin
      issue(kind < 4'd9 || kind == 4'd15, kind >= 4'd9, r[6:4], a, {next_rand(), next_rand()});
      last_addr = a;
    end
  endtask

  // Idle until the pipeline is empty, bounded by 50 cycles.
  task automatic drain_pipeline();
    int cycles;
    cycles = 0;
    issue(1'b0, 1'b0, OP_B, '0, '0);
    while ((in_flight != 0 || done) && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (in_flight != 0 || done) begin
      $display("Timeout: pipeline still busy after %0d idle cycles", cycles);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    rand_state = 32'hd25e;
    last_addr  = '0;
    timed_out  = 1'b0;
    rst        = 1'b1;
    mem_rd     = 1'b0;
    mem_wr     = 1'b0;
    mem_op     = OP_B;
    addr       = '0;
    wdata      = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    // Fill every word with a known doubleword.
    for (int w = 0; w < MEM_WORDS; w++) begin
      issue(1'b0, 1'b1, OP_D, ADDR_W'(w * LANES), {next_rand(), next_rand()});
    end
    for (int n = 0; n < 3000; n++) begin
      random_cycle();
    end
    drain_pipeline();
    $display("Errors: %0d, loads skipped for unknown bytes: %0d", errors, skipped);
    if (errors == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/lsu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_checker import lsu_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                mem_rd,
  input  wire logic                mem_wr,
  input  wire logic [OP_WIDTH-1:0] mem_op,
  input  wire logic [ADDR_W-1:0]   addr,
  input  wire logic [XLEN-1:0]     wdata,
  input  wire logic                done,
  input  wire logic                fault,
  input  wire logic [XLEN-1:0]     rdata,
  output int                       errors,
  output int                       skipped,
  output int                       in_flight
);

  // Byte model of the whole address space.
  logic [7:0] model_mem [1 << ADDR_W];
  logic       model_known [1 << ADDR_W];

  // Expected results, entry 0 is the newest request.
  logic            exp_valid [3];
  logic            exp_fault [3];
  logic            exp_check [3];
  logic [XLEN-1:0] exp_data [3];
  logic            armed;

  // Access size in bytes, from the access code.
  function automatic int size_of(input logic [OP_WIDTH-1:0] op);
    case (op)
      OP_B, OP_BU: return 1;
      OP_H, OP_HU: return 2;
      OP_W, OP_WU: return 4;
      default:     return 8;
    endcase
  endfunction

  // Fill the bits above the access size with zeros or the top data bit.
  function automatic logic [XLEN-1:0] extend(input logic [XLEN-1:0] raw, input int sz,
                                             input logic sgn);
    logic [XLEN-1:0] v;
    int              nbits;
    nbits = sz * 8;
    v     = raw;
    for (int b = nbits; b < XLEN; b++) begin
      v[b] = sgn ? raw[nbits-1] : 1'b0;
    end
    return v;
  endfunction

  initial begin
    errors    = 0;
    skipped   = 0;
    in_flight = 0;
    armed     = 1'b0;
    for (int i = 0; i < (1 << ADDR_W); i++) begin
      model_known[i] = 1'b0;
    end
  end

  // Sample the request and update the model in issue order.
  always @(posedge clk) begin
    int              sz;
    int              a;
    logic            all_known;
    logic [XLEN-1:0] raw;
    for (int s = 2; s > 0; s--) begin
      exp_valid[s] = exp_valid[s-1];
      exp_fault[s] = exp_fault[s-1];
      exp_check[s] = exp_check[s-1];
      exp_data[s]  = exp_data[s-1];
    end
    exp_valid[0] = 1'b0;
    exp_fault[0] = 1'b0;
    exp_check[0] = 1'b1;
    exp_data[0]  = '0;
    if (rst) begin
      armed = 1'b1;
      for (int s = 1; s < 3; s++) begin
        exp_valid[s] = 1'b0;
        exp_fault[s] = 1'b0;
        exp_check[s] = 1'b1;
        exp_data[s]  = '0;
      end
    end else if (mem_rd || mem_wr) begin
      sz = size_of(mem_op);
      a  = int'(addr);
      exp_valid[0] = 1'b1;
      // Both strobes, unsigned store, reserved load or misaligned address.
      exp_fault[0] = (mem_rd && mem_wr) || (mem_wr && mem_op >= 3'b100) ||
                     (mem_rd && mem_op == OP_BAD) || (a % sz != 0);
      if (!exp_fault[0] && mem_wr) begin
        for (int i = 0; i < sz; i++) begin
          model_mem[a+i]   = wdata[i*8 +: 8];
          model_known[a+i] = 1'b1;
        end
      end else if (!exp_fault[0]) begin
        raw       = '0;
        all_known = 1'b1;
        for (int i = 0; i < sz; i++) begin
          raw[i*8 +: 8] = model_mem[a+i];
          all_known     = all_known & model_known[a+i];
        end
        if (all_known) begin
          exp_data[0] = extend(raw, sz, ~mem_op[2]);
        end else begin
          exp_check[0] = 1'b0;
          skipped++;
        end
      end
    end
    in_flight = int'(exp_valid[0]) + int'(exp_valid[1]) + int'(exp_valid[2]);
  end

  // Outputs are settled at the falling edge, entry 2 is due now.
  always @(negedge clk) begin
    if (armed) begin
      if (done !== exp_valid[2]) begin
        $display("[FAIL] %0t: done is %b, expected %b", $time, done, exp_valid[2]);
        errors++;
      end
      if (fault !== exp_fault[2]) begin
        $display("[FAIL] %0t: fault is %b, expected %b", $time, fault, exp_fault[2]);
        errors++;
      end
      if (exp_check[2] && rdata !== exp_data[2]) begin
        $display("[FAIL] %0t: rdata is %h, expected %h", $time, rdata, exp_data[2]);
        errors++;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                mem_rd,
  input  wire logic                mem_wr,
  input  wire logic [OP_WIDTH-1:0] mem_op,
  input  wire logic [ADDR_W-1:0]   addr,
  input  wire logic [XLEN-1:0]     wdata,
  output logic                     done,
  output logic                     fault,
  output logic [XLEN-1:0]          rdata
);

  // Stage links.
  lsu_req_if req_bus ();
  lsu_mem_if mem_bus ();

  // Check, mask and replicate.
  lsu_request_stage u_request (
    .clk    (clk),
    .rst    (rst),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr),
    .mem_op (mem_op),
    .addr   (addr),
    .wdata  (wdata),
    .req    (req_bus.src)
  );

  // Masked RAM with registered read.
  lsu_data_ram u_ram (
    .clk (clk),
    .rst (rst),
    .req (req_bus.dst),
    .rsp (mem_bus.src)
  );

  // Lane select, extend, output register.
  lsu_load_align u_align (
    .clk   (clk),
    .rst   (rst),
    .rsp   (mem_bus.dst),
    .done  (done),
    .fault (fault),
    .rdata (rdata)
  );

endmodule

`default_nettype wire

// File: design/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst,
  lsu_mem_if.dst               rsp,
  output logic                 done,
  output logic                 fault,
  output logic [XLEN-1:0]      rdata
);

  logic [7:0]      byte_sel;
  logic [15:0]     half_sel;
  logic [31:0]     word_sel;
  logic [XLEN-1:0] ext;
  logic            load_ok;

  // Lane pick from the union views.
  // Half and word offsets are aligned when the beat is legal.
  assign byte_sel = rsp.rdata.bytes[rsp.offset];
  assign half_sel = rsp.rdata.halves[rsp.offset[2:1]];
  assign word_sel = rsp.rdata.words[rsp.offset[2]];

  // Sign or zero extension by access code.
  always_comb begin
    case (rsp.op)
      OP_B:    ext = {{(XLEN-8){byte_sel[7]}}, byte_sel};
      OP_BU:   ext = {{(XLEN-8){1'b0}}, byte_sel};
      OP_H:    ext = {{(XLEN-16){half_sel[15]}}, half_sel};
      OP_HU:   ext = {{(XLEN-16){1'b0}}, half_sel};
      OP_W:    ext = {{(XLEN-32){word_sel[31]}}, word_sel};
      OP_WU:   ext = {{(XLEN-32){1'b0}}, word_sel};
      OP_D:    ext = rsp.rdata.dword;
      // Reserved code, always a fault upstream.
      default: ext = '0;
    endcase
  end

  // Only a clean load returns data.
  assign load_ok = rsp.valid & rsp.is_load & ~rsp.fault;

  // Output register.
  // Idle cycles, stores and faults all show zero data.
  always_ff @(posedge clk) begin
    if (rst) begin
      done  <= 1'b0;
      fault <= 1'b0;
      rdata <= '0;
    end else begin
      done  <= rsp.valid;
      fault <= rsp.valid & rsp.fault;
      rdata <= load_ok ? ext : '0;
    end
  end

endmodule

`default_nettype wire

// File: design/lsu_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_data_ram import lsu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  lsu_req_if.dst    req,
  lsu_mem_if.src    rsp
);

  // Data array, byte lanes written separately.
  mem_word_u mem [MEM_WORDS];

  logic wr_en;

  // Write only for a clean store beat.
  assign wr_en = req.valid & ~req.is_load & ~req.fault;

  // Masked write, one lane at a time.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < LANES; i++) begin
        if (req.wmask[i]) begin
          mem[req.word_idx].bytes[i] <= req.wdata.bytes[i];
        end
      end
    end
  end

  // Registered read of the addressed word, every cycle.
  // A store in this same cycle returns old data, but stores drop it later.
  always_ff @(posedge clk) begin
    rsp.rdata <= mem[req.word_idx];
  end

  // Beat valid moves one stage on.
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp.valid <= 1'b0;
    end else begin
      rsp.valid <= req.valid;
    end
  end

  // Context beside the read data.
  always_ff @(posedge clk) begin
    rsp.is_load <= req.is_load;
    rsp.fault   <= req.fault;
    rsp.op      <= req.op;
    rsp.offset  <= req.offset;
  end

endmodule

`default_nettype wire

// File: design/lsu_request_stage.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_request_stage import lsu_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                mem_rd,
  input  wire logic                mem_wr,
  input  wire logic [OP_WIDTH-1:0] mem_op,
  input  wire logic [ADDR_W-1:0]   addr,
  input  wire logic [XLEN-1:0]     wdata,
  lsu_req_if.src                   req
);

  logic                active;
  logic                bad_op;
  logic                misaligned;
  logic                fault_c;
  logic [OFFSET_W-1:0] off;
  logic [LANES-1:0]    lane_mask;
  logic [LANES-1:0]    wmask_c;
  mem_word_u           wdata_rep;

  // Any strobe makes this cycle a request.
  assign active = mem_rd | mem_wr;
  assign off    = addr[OFFSET_W-1:0];

  // Both strobes, store with an unsigned code, or the reserved code.
  assign bad_op = (mem_rd & mem_wr) |
                  (mem_wr & mem_op[2]) |
                  (mem_rd & (mem_op == OP_BAD));

  // Alignment and lane mask both follow the size field.
  always_comb begin
    misaligned = 1'b0;
    lane_mask  = '0;
    wdata_rep  = '0;
    case (mem_op[1:0])
      SZ_B: begin
        lane_mask       = 8'b0000_0001 << off;
        wdata_rep.bytes = {LANES{wdata[7:0]}};
      end
      SZ_H: begin
        misaligned       = off[0];
        lane_mask        = 8'b0000_0011 << {off[2:1], 1'b0};
        wdata_rep.halves = {4{wdata[15:0]}};
      end
      SZ_W: begin
        misaligned      = |off[1:0];
        lane_mask       = 8'b0000_1111 << {off[2], 2'b00};
        wdata_rep.words = {2{wdata[31:0]}};
      end
      default: begin
        // Doubleword, all lanes.
        misaligned      = |off;
        lane_mask       = '1;
        wdata_rep.dword = wdata;
      end
    endcase
  end

  assign fault_c = bad_op | misaligned;

  // Only a clean store may enable lanes.
  assign wmask_c = (mem_wr && !mem_rd && !fault_c) ? lane_mask : '0;

  // Input register, one beat per request.
  always_ff @(posedge clk) begin
    if (rst) begin
      req.valid <= 1'b0;
      req.fault <= 1'b0;
    end else begin
      req.valid <= active;
      req.fault <= active & fault_c;
    end
  end

  // Payload fields carry no reset.
  always_ff @(posedge clk) begin
    req.is_load  <= mem_rd;
    req.op       <= mem_op;
    req.offset   <= off;
    req.word_idx <= addr[ADDR_W-1:OFFSET_W];
    req.wmask    <= wmask_c;
    req.wdata    <= wdata_rep;
  end

endmodule

`default_nettype wire

// File: design/lsu_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

// Raw read word plus access context, memory stage to align stage.
interface lsu_mem_if import lsu_pkg::*;;

  logic                valid;
  logic                is_load;
  logic                fault;
  // Op and offset steer the lane pick downstream.
  logic [OP_WIDTH-1:0] op;
  logic [OFFSET_W-1:0] offset;
  // Whole addressed word, not yet aligned.
  mem_word_u           rdata;

  modport src (
    output valid, is_load, fault, op, offset, rdata
  );

  modport dst (
    input valid, is_load, fault, op, offset, rdata
  );

endinterface

`default_nettype wire

// File: design/lsu_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// Checked request, request stage to memory stage.
interface lsu_req_if import lsu_pkg::*;;

  logic                valid;
  logic                is_load;
  logic                fault;
  logic [OP_WIDTH-1:0] op;
  logic [OFFSET_W-1:0] offset;
  logic [WORD_AW-1:0]  word_idx;
  // Byte write enables, zero for loads and faults.
  logic [LANES-1:0]    wmask;
  // Store data, already copied into every lane.
  mem_word_u           wdata;

  modport src (
    output valid, is_load, fault, op, offset, word_idx, wmask, wdata
  );

  modport dst (
    input valid, is_load, fault, op, offset, word_idx, wmask, wdata
  );

endinterface

`default_nettype wire

// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // Data path and memory geometry.
  localparam int XLEN      = 64;
  localparam int LANES     = 8;
  localparam int ADDR_W    = 8;
  localparam int WORD_AW   = 5;
  localparam int MEM_WORDS = 32;
  // Byte offset inside one memory word.
  localparam int OFFSET_W  = 3;

  // Access code width. The word code below takes the name OP_W.
  localparam int OP_WIDTH  = 3;

  // Signed loads, or stores of the given size.
  localparam logic [OP_WIDTH-1:0] OP_B  = 3'b000;
  localparam logic [OP_WIDTH-1:0] OP_H  = 3'b001;
  localparam logic [OP_WIDTH-1:0] OP_W  = 3'b010;
  localparam logic [OP_WIDTH-1:0] OP_D  = 3'b011;
  // Unsigned loads only.
  localparam logic [OP_WIDTH-1:0] OP_BU = 3'b100;
  localparam logic [OP_WIDTH-1:0] OP_HU = 3'b101;
  localparam logic [OP_WIDTH-1:0] OP_WU = 3'b110;
  // Code 111 is illegal for both loads and stores.
  localparam logic [OP_WIDTH-1:0] OP_BAD = 3'b111;

  // Size field, the low two bits of an access code.
  localparam logic [1:0] SZ_B = 2'b00;
  localparam logic [1:0] SZ_H = 2'b01;
  localparam logic [1:0] SZ_W = 2'b10;
  localparam logic [1:0] SZ_D = 2'b11;

  // One memory word, seen as lanes or as a whole. Lane 0 is the LSB end.
  typedef union packed {
    logic [LANES-1:0][7:0] bytes;
    logic [3:0][15:0]      halves;
    logic [1:0][31:0]      words;
    logic [XLEN-1:0]       dword;
  } mem_word_u;

endpackage

`default_nettype wire
